// ==== src/dcache_pkg.sv ====
package dcache_pkg;

    // Cache geometry
    localparam int DCACHE_LINES      = 8;
    localparam int LINE_INDEX_BITS   = $clog2(DCACHE_LINES);
    localparam int BLOCK_BYTES       = 8;
    localparam int BLOCK_OFFSET_BITS = $clog2(BLOCK_BYTES);
    localparam int LINE_TAG_BITS     = 32 - BLOCK_OFFSET_BITS;

    // Miss tracking; tag value 0 means no transaction
    localparam int MSHR_DEPTH      = 4;
    localparam int MSHR_INDEX_BITS = $clog2(MSHR_DEPTH);
    localparam int MEM_TAG_BITS    = 4;

    // Victim selection LFSR, polynomial x^8 + x^6 + x^5 + x^4 + 1
    localparam int             LFSR_BITS = 8;
    localparam logic [7:0]     LFSR_TAPS = 8'hb8;
    localparam logic [7:0]     LFSR_SEED = 8'h5a;

    typedef logic [31:0]             addr_t;
    typedef logic [31:0]             data_t;
    typedef logic [MEM_TAG_BITS-1:0] mem_tag_t;

    // One line, seen as words or bytes
    typedef union packed {
        logic [1:0][31:0]            word_level;
        logic [BLOCK_BYTES-1:0][7:0] byte_level;
    } mem_block_t;

    typedef struct packed {
        logic [LINE_TAG_BITS-1:0]     tag;
        logic [BLOCK_OFFSET_BITS-1:0] block_offset;
    } line_addr_t;

    typedef struct packed {
        logic       valid;
        line_addr_t addr;
    } line_addr_packet_t;

    typedef struct packed {
        logic       valid;
        mem_block_t data;
    } cache_data_t;

    typedef struct packed {
        logic                     valid;
        logic                     dirty;
        logic [LINE_TAG_BITS-1:0] tag;
        mem_block_t               data;
    } cache_line_t;

    typedef struct packed {
        logic       valid;
        mem_tag_t   mem_tag;
        line_addr_t addr;
    } miss_entry_t;

    typedef enum logic [1:0] {
        STORE_BYTE = 2'd0,
        STORE_HALF = 2'd1,
        STORE_WORD = 2'd2
    } store_size_e;

endpackage

// ==== src/dcache_array.sv ====
`timescale 1ns/1ps

module dcache_array import dcache_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,

    // Load lookups, index 0 is older
    input  line_addr_packet_t [1:0] read_addrs,
    output cache_data_t [1:0]       load_results,

    // Store lookup and merge
    input  line_addr_packet_t       store_lookup,
    output logic                    store_hit,
    input  logic                    store_en,
    input  mem_block_t              store_block,
    input  logic [BLOCK_BYTES-1:0]  store_byte_en,

    // Refill from memory
    input  line_addr_packet_t       refill_addr,
    input  mem_block_t              refill_data,

    // Line displaced by a refill
    output cache_line_t             evicted_line,
    output logic                    evicted_valid
);

    cache_line_t [DCACHE_LINES-1:0] lines;
    cache_line_t                    line_write;
    logic [DCACHE_LINES-1:0]        write_mask;
    logic [LINE_INDEX_BITS-1:0]     free_index;
    logic                           free_found;
    logic [LINE_INDEX_BITS-1:0]     victim_index;
    logic [LINE_INDEX_BITS-1:0]     hit_index;
    logic [LFSR_BITS-1:0]           lfsr;
    mem_block_t                     merged_data;

    // Galois LFSR, free running
    always_ff @(posedge clock) begin
        if (reset) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {1'b0, lfsr[LFSR_BITS-1:1]} ^ (lfsr[0] ? LFSR_TAPS : '0);
        end
    end

    assign victim_index = lfsr[LINE_INDEX_BITS-1:0];

    // Load ports hit combinationally
    always_comb begin
        load_results = '0;
        for (int j = 0; j < 2; j++) begin
            for (int i = 0; i < DCACHE_LINES; i++) begin
                if (read_addrs[j].valid && lines[i].valid &&
                    (lines[i].tag == read_addrs[j].addr.tag)) begin
                    load_results[j].valid = 1'b1;
                    load_results[j].data  = lines[i].data;
                end
            end
        end
    end

    // Store lookup
    always_comb begin
        store_hit = 1'b0;
        hit_index = '0;
        for (int i = 0; i < DCACHE_LINES; i++) begin
            if (store_lookup.valid && lines[i].valid &&
                (lines[i].tag == store_lookup.addr.tag)) begin
                store_hit = 1'b1;
                hit_index = LINE_INDEX_BITS'(i);
            end
        end
    end

    // Lowest numbered free line wins
    always_comb begin
        free_found = 1'b0;
        free_index = '0;
        for (int i = DCACHE_LINES - 1; i >= 0; i--) begin
            if (!lines[i].valid) begin
                free_found = 1'b1;
                free_index = LINE_INDEX_BITS'(i);
            end
        end
    end

    // Write select, refill before store
    always_comb begin
        write_mask    = '0;
        line_write    = '0;
        evicted_line  = '0;
        evicted_valid = 1'b0;
        merged_data   = lines[hit_index].data;
        if (refill_addr.valid) begin
            line_write.valid = 1'b1;
            line_write.dirty = 1'b0;
            line_write.tag   = refill_addr.addr.tag;
            line_write.data  = refill_data;
            if (free_found) begin
                write_mask[free_index] = 1'b1;
            end else begin
                write_mask[victim_index] = 1'b1;
                evicted_line  = lines[victim_index];
                evicted_valid = 1'b1;
            end
        end else if (store_en && store_hit) begin
            for (int b = 0; b < BLOCK_BYTES; b++) begin
                if (store_byte_en[b]) begin
                    merged_data.byte_level[b] = store_block.byte_level[b];
                end
            end
            write_mask[hit_index] = 1'b1;
            line_write.valid = 1'b1;
            line_write.dirty = 1'b1;
            line_write.tag   = lines[hit_index].tag;
            line_write.data  = merged_data;
        end
    end

    // Only valid and dirty need clearing
    always_ff @(posedge clock) begin
        for (int i = 0; i < DCACHE_LINES; i++) begin
            if (reset) begin
                lines[i].valid <= 1'b0;
                lines[i].dirty <= 1'b0;
            end else if (write_mask[i]) begin
                lines[i] <= line_write;
            end
        end
    end

endmodule

// ==== src/miss_status_file.sv ====
`timescale 1ns/1ps

module miss_status_file import dcache_pkg::*; (
    input  logic              clock,
    input  logic              reset,

    // Duplicate check for the next request
    input  line_addr_t        snoop_addr,
    output logic              addr_pending,

    // Accepted request
    input  miss_entry_t       new_entry,

    // Data return, popped in request order
    input  mem_tag_t          mem_data_tag,
    output line_addr_packet_t refill_addr
);

    miss_entry_t [MSHR_DEPTH-1:0] entries;
    logic [MSHR_INDEX_BITS-1:0]   head;
    logic [MSHR_INDEX_BITS-1:0]   tail;
    logic                         pop;

    function automatic logic [MSHR_INDEX_BITS-1:0] next_ptr(
        input logic [MSHR_INDEX_BITS-1:0] ptr
    );
        if (ptr == MSHR_INDEX_BITS'(MSHR_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_comb begin
        addr_pending = 1'b0;
        for (int i = 0; i < MSHR_DEPTH; i++) begin
            if (entries[i].valid && (entries[i].addr.tag == snoop_addr.tag)) begin
                addr_pending = 1'b1;
            end
        end
    end

    // Memory returns in order, so only the head can match
    assign pop = (mem_data_tag != '0) && entries[head].valid &&
                 (entries[head].mem_tag == mem_data_tag);

    always_comb begin
        refill_addr = '0;
        if (pop) begin
            refill_addr.valid = 1'b1;
            refill_addr.addr  = entries[head].addr;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < MSHR_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            if (pop) begin
                entries[head].valid <= 1'b0;
                head <= next_ptr(head);
            end
            if (new_entry.valid) begin
                entries[tail] <= new_entry;
                tail <= next_ptr(tail);
            end
        end
    end

endmodule

// ==== src/dcache_control.sv ====
`timescale 1ns/1ps

module dcache_control import dcache_pkg::*; (
    // Store port
    input  logic                    store_valid,
    input  addr_t                   store_addr,
    input  data_t                   store_data,
    input  store_size_e             store_size,
    output logic                    store_done,

    // Array side
    input  line_addr_packet_t [1:0] read_addrs,
    input  cache_data_t [1:0]       load_results,
    input  logic                    store_hit,
    input  cache_line_t             evicted_line,
    input  logic                    evicted_valid,
    output line_addr_packet_t       store_lookup,
    output logic                    store_en,
    output mem_block_t              store_block,
    output logic [BLOCK_BYTES-1:0]  store_byte_en,

    // Miss file side
    input  line_addr_packet_t       refill_addr,
    input  logic                    addr_pending,
    output line_addr_t              snoop_addr,
    output miss_entry_t             new_entry,

    // Memory side
    input  logic                    mem_req_accepted,
    input  mem_tag_t                req_tag,
    output line_addr_packet_t       mem_req_addr,
    output logic                    mem_write_valid,
    output line_addr_packet_t       mem_write_addr,
    output mem_block_t              mem_write_data
);

    logic [BLOCK_OFFSET_BITS-1:0] lane_offset;
    logic [BLOCK_BYTES-1:0]       size_mask;
    data_t                        size_data;
    line_addr_packet_t            oldest_miss;

    // Size sets the lane alignment and the bytes kept
    always_comb begin
        case (store_size)
            STORE_BYTE: begin
                lane_offset = store_addr[2:0];
                size_mask   = 8'h01;
                size_data   = {24'b0, store_data[7:0]};
            end
            STORE_HALF: begin
                lane_offset = {store_addr[2:1], 1'b0};
                size_mask   = 8'h03;
                size_data   = {16'b0, store_data[15:0]};
            end
            default: begin
                lane_offset = {store_addr[2], 2'b00};
                size_mask   = 8'h0f;
                size_data   = store_data;
            end
        endcase
    end

    always_comb begin
        store_lookup = '0;
        if (store_valid) begin
            store_lookup.valid             = 1'b1;
            store_lookup.addr.tag          = store_addr[31:BLOCK_OFFSET_BITS];
            store_lookup.addr.block_offset = store_addr[BLOCK_OFFSET_BITS-1:0];
        end
    end

    assign store_block   = mem_block_t'({32'b0, size_data} << {lane_offset, 3'b000});
    assign store_byte_en = store_valid ? (size_mask << lane_offset) : '0;

    // A refill owns the array write port this cycle
    assign store_en   = store_valid && store_hit && !refill_addr.valid;
    assign store_done = store_en;

    // Store miss first, then the older load
    always_comb begin
        oldest_miss = '0;
        if (store_valid && !store_hit) begin
            oldest_miss.valid    = 1'b1;
            oldest_miss.addr.tag = store_addr[31:BLOCK_OFFSET_BITS];
        end else if (read_addrs[0].valid && !load_results[0].valid) begin
            oldest_miss.valid = 1'b1;
            oldest_miss.addr  = read_addrs[0].addr;
        end else if (read_addrs[1].valid && !load_results[1].valid) begin
            oldest_miss.valid = 1'b1;
            oldest_miss.addr  = read_addrs[1].addr;
        end
    end

    assign snoop_addr = oldest_miss.addr;

    // Dirty victims go straight out, memory never stalls a write
    assign mem_write_valid            = evicted_valid && evicted_line.dirty;
    assign mem_write_addr.valid       = mem_write_valid;
    assign mem_write_addr.addr        = {evicted_line.tag, {BLOCK_OFFSET_BITS{1'b0}}};
    assign mem_write_data             = evicted_line.data;

    always_comb begin
        mem_req_addr = '0;
        if (oldest_miss.valid && !mem_write_valid && !addr_pending) begin
            mem_req_addr = oldest_miss;
        end
    end

    always_comb begin
        new_entry = '0;
        if (mem_req_addr.valid && mem_req_accepted && (req_tag != '0)) begin
            new_entry.valid   = 1'b1;
            new_entry.mem_tag = req_tag;
            new_entry.addr    = mem_req_addr.addr;
        end
    end

endmodule

// ==== src/dcache_subsystem.sv ====
`timescale 1ns/1ps

module dcache_subsystem import dcache_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,

    // Loads, index 0 is older
    input  line_addr_packet_t [1:0] read_addrs,
    output cache_data_t [1:0]       cache_outs,

    // Stores, held until store_done
    input  logic                    store_valid,
    input  addr_t                   store_addr,
    input  data_t                   store_data,
    input  store_size_e             store_size,
    output logic                    store_done,

    // Read requests and tagged returns
    output line_addr_packet_t       mem_req_addr,
    input  logic                    mem_req_accepted,
    input  mem_tag_t                req_tag,
    input  mem_block_t              mem_data,
    input  mem_tag_t                mem_data_tag,

    // Writebacks
    output logic                    mem_write_valid,
    output line_addr_packet_t       mem_write_addr,
    output mem_block_t              mem_write_data
);

    line_addr_packet_t      store_lookup;
    line_addr_packet_t      refill_addr;
    logic                   store_en;
    logic                   store_hit;
    mem_block_t             store_block;
    logic [BLOCK_BYTES-1:0] store_byte_en;
    cache_line_t            evicted_line;
    logic                   evicted_valid;
    line_addr_t             snoop_addr;
    miss_entry_t            new_entry;
    logic                   addr_pending;

    dcache_array dcache_array_inst (
        .clock         (clock),
        .reset         (reset),
        .read_addrs    (read_addrs),
        .load_results  (cache_outs),
        .store_lookup  (store_lookup),
        .store_hit     (store_hit),
        .store_en      (store_en),
        .store_block   (store_block),
        .store_byte_en (store_byte_en),
        .refill_addr   (refill_addr),
        .refill_data   (mem_data),
        .evicted_line  (evicted_line),
        .evicted_valid (evicted_valid)
    );

    miss_status_file miss_status_file_inst (
        .clock        (clock),
        .reset        (reset),
        .snoop_addr   (snoop_addr),
        .addr_pending (addr_pending),
        .new_entry    (new_entry),
        .mem_data_tag (mem_data_tag),
        .refill_addr  (refill_addr)
    );

    dcache_control dcache_control_inst (
        .store_valid      (store_valid),
        .store_addr       (store_addr),
        .store_data       (store_data),
        .store_size       (store_size),
        .store_done       (store_done),
        .read_addrs       (read_addrs),
        .load_results     (cache_outs),
        .store_hit        (store_hit),
        .evicted_line     (evicted_line),
        .evicted_valid    (evicted_valid),
        .store_lookup     (store_lookup),
        .store_en         (store_en),
        .store_block      (store_block),
        .store_byte_en    (store_byte_en),
        .refill_addr      (refill_addr),
        .addr_pending     (addr_pending),
        .snoop_addr       (snoop_addr),
        .new_entry        (new_entry),
        .mem_req_accepted (mem_req_accepted),
        .req_tag          (req_tag),
        .mem_req_addr     (mem_req_addr),
        .mem_write_valid  (mem_write_valid),
        .mem_write_addr   (mem_write_addr),
        .mem_write_data   (mem_write_data)
    );

endmodule

// ==== tests/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb import dcache_pkg::*; ();

    localparam int WAIT_LIMIT = 200;

    logic                    clock = 1'b0;
    logic                    reset;
    line_addr_packet_t [1:0] read_addrs;
    cache_data_t [1:0]       cache_outs;
    logic                    store_valid;
    addr_t                   store_addr;
    data_t                   store_data;
    store_size_e             store_size;
    logic                    store_done;
    line_addr_packet_t       mem_req_addr;
    logic                    mem_req_accepted;
    mem_tag_t                req_tag = 4'd1;
    mem_block_t              mem_data = '0;
    mem_tag_t                mem_data_tag = '0;
    logic                    mem_write_valid;
    line_addr_packet_t       mem_write_addr;
    mem_block_t              mem_write_data;

    // Memory model state and the reference copy of stored lines
    mem_block_t memory [addr_t];
    mem_block_t ref_lines [addr_t];
    bit         ref_dirty [addr_t];
    mem_tag_t   pend_tag [$];
    addr_t      pend_addr [$];
    int         pend_due [$];
    int         cycle_count = 0;
    int         last_due = 0;
    int         writebacks = 0;
    logic       take_tag = 1'b0;
    integer     seed = 32'hc4b3_e95f;

    always #50 clock = ~clock;

    assign mem_req_accepted = 1'b1;

    dcache_subsystem dcache_subsystem_inst (
        .clock            (clock),
        .reset            (reset),
        .read_addrs       (read_addrs),
        .cache_outs       (cache_outs),
        .store_valid      (store_valid),
        .store_addr       (store_addr),
        .store_data       (store_data),
        .store_size       (store_size),
        .store_done       (store_done),
        .mem_req_addr     (mem_req_addr),
        .mem_req_accepted (mem_req_accepted),
        .req_tag          (req_tag),
        .mem_data         (mem_data),
        .mem_data_tag     (mem_data_tag),
        .mem_write_valid  (mem_write_valid),
        .mem_write_addr   (mem_write_addr),
        .mem_write_data   (mem_write_data)
    );

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_cache_data(input string name, input cache_data_t expected,
                                    input cache_data_t actual);
        if (actual !== expected) begin
            stop_run($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic check_block(input string name, input mem_block_t expected,
                               input mem_block_t actual);
        if (actual !== expected) begin
            stop_run($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic check_done(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_run($sformatf("mismatch %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    task automatic check_request(input string name, input line_addr_packet_t expected,
                                 input line_addr_packet_t actual);
        if (actual !== expected) begin
            stop_run($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    function automatic addr_t line_of(input addr_t a);
        return {a[31:3], 3'b000};
    endfunction

    function automatic line_addr_packet_t packet_of(input addr_t a);
        line_addr_packet_t p;
        p.valid = 1'b1;
        p.addr  = a;
        return p;
    endfunction

    function automatic cache_data_t hit_of(input mem_block_t blk);
        cache_data_t c;
        c.valid = 1'b1;
        c.data  = blk;
        return c;
    endfunction

    // Untouched memory holds the inverted line address above the address itself
    function automatic mem_block_t mem_read(input addr_t line);
        mem_block_t blk;
        if (memory.exists(line)) begin
            return memory[line];
        end
        blk.word_level[1] = ~line;
        blk.word_level[0] = line;
        return blk;
    endfunction

    function automatic mem_block_t expected_line(input addr_t line);
        if (ref_lines.exists(line)) begin
            return ref_lines[line];
        end
        return mem_read(line);
    endfunction

    // Little endian lanes aligned to the store size
    function automatic void apply_store(input addr_t a, input data_t d, input store_size_e size);
        mem_block_t blk;
        int         lane;
        int         nbytes;
        blk = expected_line(line_of(a));
        case (size)
            STORE_BYTE: begin
                lane   = int'(a[2:0]);
                nbytes = 1;
            end
            STORE_HALF: begin
                lane   = int'({a[2:1], 1'b0});
                nbytes = 2;
            end
            default: begin
                lane   = int'({a[2], 2'b00});
                nbytes = 4;
            end
        endcase
        for (int k = 0; k < nbytes; k++) begin
            blk.byte_level[lane + k] = d[8*k +: 8];
        end
        ref_lines[line_of(a)] = blk;
        ref_dirty[line_of(a)] = 1'b1;
    endfunction

    function automatic bit line_in_flight(input addr_t line);
        foreach (pend_addr[i]) begin
            if (pend_addr[i] == line) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Requests and writebacks are sampled mid cycle
    always @(negedge clock) begin
        addr_t req_line;
        addr_t wb_line;
        int    lat;
        take_tag = 1'b0;
        if (!reset) begin
            if (mem_req_addr.valid) begin
                req_line = line_of(mem_req_addr.addr);
                if (line_in_flight(req_line)) begin
                    stop_run("a second read request was made for a line already in flight");
                end
                lat = 2 + int'($unsigned($random(seed)) % 4);
                last_due = (cycle_count + lat > last_due) ? cycle_count + lat : last_due + 1;
                pend_tag.push_back(req_tag);
                pend_addr.push_back(req_line);
                pend_due.push_back(last_due);
                take_tag = 1'b1;
            end
            if (mem_write_valid) begin
                wb_line = line_of(mem_write_addr.addr);
                if (!ref_dirty.exists(wb_line) || !ref_dirty[wb_line]) begin
                    stop_run($sformatf("writeback of line %h that holds no stored data", wb_line));
                end
                check_request("writeback address", packet_of(wb_line), mem_write_addr);
                check_block("writeback data", ref_lines[wb_line], mem_write_data);
                memory[wb_line]    = mem_write_data;
                ref_dirty[wb_line] = 1'b0;
                writebacks++;
            end
        end
    end

    // Tags run 1 to 15 and returns leave in request order
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (reset) begin
            req_tag      <= 4'd1;
            mem_data_tag <= '0;
            mem_data     <= '0;
        end else begin
            if (take_tag) begin
                req_tag <= (req_tag == 4'd15) ? 4'd1 : req_tag + 4'd1;
            end
            mem_data_tag <= '0;
            if (pend_tag.size() > 0 && pend_due[0] <= cycle_count) begin
                mem_data_tag <= pend_tag.pop_front();
                mem_data     <= mem_read(pend_addr.pop_front());
                void'(pend_due.pop_front());
            end
        end
    end

    task automatic load_until_hit(input int line_no, input addr_t a0, input addr_t a1,
                                  input mem_block_t expected);
        int   waits;
        logic done;
        waits = 0;
        done  = 1'b0;
        @(posedge clock);
        read_addrs[0] <= packet_of(a0);
        if (a1 != '0) begin
            read_addrs[1] <= packet_of(a1);
        end
        @(negedge clock);
        if (!cache_outs[0].valid) begin
            check_request($sformatf("load request, data line %0d", line_no),
                          packet_of(line_of(a0)), mem_req_addr);
        end
        while (!done) begin
            if (cache_outs[0].valid && (a1 == '0 || cache_outs[1].valid)) begin
                done = 1'b1;
            end else begin
                waits++;
                if (waits > WAIT_LIMIT) begin
                    stop_run($sformatf("load on data line %0d never hit", line_no));
                end
                @(negedge clock);
            end
        end
        check_cache_data($sformatf("load port 0, data line %0d", line_no),
                         hit_of(expected), cache_outs[0]);
        if (a1 != '0) begin
            check_cache_data($sformatf("load port 1, data line %0d", line_no),
                             hit_of(expected_line(line_of(a1))), cache_outs[1]);
        end
        @(posedge clock);
        read_addrs <= '0;
    endtask

    task automatic store_until_done(input int line_no, input addr_t a, input data_t d,
                                    input store_size_e size, input addr_t load_a);
        int waits;
        waits = 0;
        @(posedge clock);
        store_valid <= 1'b1;
        store_addr  <= a;
        store_data  <= d;
        store_size  <= size;
        if (load_a != '0) begin
            read_addrs[0] <= packet_of(load_a);
        end
        @(negedge clock);
        // A missing store is requested ahead of any load
        if (!store_done) begin
            check_request($sformatf("first request, data line %0d", line_no),
                          packet_of(line_of(a)), mem_req_addr);
        end
        while (!store_done) begin
            waits++;
            if (waits > WAIT_LIMIT) begin
                stop_run($sformatf("store on data line %0d never completed", line_no));
            end
            @(negedge clock);
        end
        apply_store(a, d, size);
        @(posedge clock);
        store_valid <= 1'b0;
        @(negedge clock);
        check_done($sformatf("store_done release, data line %0d", line_no), 1'b0, store_done);
        if (load_a != '0) begin
            waits = 0;
            while (!cache_outs[0].valid) begin
                waits++;
                if (waits > WAIT_LIMIT) begin
                    stop_run($sformatf("load beside store on data line %0d never hit", line_no));
                end
                @(negedge clock);
            end
            check_cache_data($sformatf("load beside store, data line %0d", line_no),
                             hit_of(expected_line(line_of(load_a))), cache_outs[0]);
            @(posedge clock);
            read_addrs <= '0;
        end
    endtask

    task automatic fill_lines(input int line_no, input addr_t base, input data_t count);
        addr_t a;
        for (int i = 0; i < int'(count); i++) begin
            a = base + addr_t'(i * 8);
            load_until_hit(line_no, a, '0, expected_line(a));
        end
    endtask

    initial begin
        int          fd;
        int          line_no;
        int          fields;
        string       line_text;
        logic [63:0] op_name;
        addr_t       op_addr;
        data_t       op_data;
        logic [31:0] op_size;
        logic [63:0] op_expected;
        reset       = 1'b1;
        read_addrs  = '0;
        store_valid = 1'b0;
        store_addr  = '0;
        store_data  = '0;
        store_size  = STORE_BYTE;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_done("reset request valid", 1'b0, mem_req_addr.valid);
        check_done("reset writeback valid", 1'b0, mem_write_valid);
        check_done("reset store_done", 1'b0, store_done);
        check_done("reset load 0 valid", 1'b0, cache_outs[0].valid);
        check_done("reset load 1 valid", 1'b0, cache_outs[1].valid);

        fd = $fopen("tests/dcache_testdata.txt", "r");
        if (fd == 0) begin
            stop_run("cannot open tests/dcache_testdata.txt");
        end
        line_no = 0;
        while (!$feof(fd)) begin
            line_no++;
            line_text = "";
            fields    = 0;
            if ($fgets(line_text, fd) != 0 && line_text.getc(0) != "#") begin
                fields = $sscanf(line_text, "%s %h %h %h %h",
                                 op_name, op_addr, op_data, op_size, op_expected);
            end
            if (fields == 5) begin
                if (op_name == 64'("LOAD")) begin
                    load_until_hit(line_no, op_addr, op_data, mem_block_t'(op_expected));
                end else if (op_name == 64'("STORE")) begin
                    store_until_done(line_no, op_addr, op_data, store_size_e'(op_size[1:0]),
                                     op_expected[31:0]);
                end else if (op_name == 64'("IDLE")) begin
                    repeat (op_data) @(posedge clock);
                end else if (op_name == 64'("FILLALL")) begin
                    fill_lines(line_no, op_addr, op_data);
                end else begin
                    stop_run($sformatf("unknown operation on data line %0d", line_no));
                end
            end
        end
        $fclose(fd);

        repeat (4) @(posedge clock);
        if (writebacks == 0) begin
            stop_run("no dirty line was written back during the run");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// ==== files.f ====
src/dcache_pkg.sv
src/dcache_array.sv
src/miss_status_file.sv
src/dcache_control.sv
src/dcache_subsystem.sv
tests/dcache_tb.sv

// ==== Makefile ====
# Verilator build and run for the data cache testbench
VERILATOR       ?= verilator
TOP             ?= dcache_tb
FILELIST        ?= files.f
BUILD_DIR       ?= obj_dir
LOG             ?= sim.log
VERILATOR_FLAGS ?= --binary --timing -Wno-fatal
PASS_TEXT       ?= Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VERILATOR_FLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/dcache_testdata.txt ====
# op      addr     data     size expected
# LOAD: expected is the port 0 block, data is a port 1 load address or 0
# STORE: size 0 byte, 1 half, 2 word; expected is a port 0 load address sent with it or 0
# FILLALL loads data lines upward from addr; IDLE waits data cycles
IDLE    00000000 00000003 0 0
LOAD    00001000 00000000 0 ffffefff00001000
LOAD    00001000 00000000 0 ffffefff00001000
STORE   00001003 000000ab 0 0
LOAD    00001000 00000000 0 ffffefffab001000
STORE   00001006 0000beef 1 0
LOAD    00001000 00000000 0 beefefffab001000
STORE   00002004 12345678 2 0
LOAD    00002000 00000000 0 1234567800002000
LOAD    00003000 00004000 0 ffffcfff00003000
STORE   00005001 00000077 0 00006000
LOAD    00005000 00000000 0 ffffafff00007700
FILLALL 00010000 00000010 0 0
LOAD    00001000 00000000 0 beefefffab001000
LOAD    00002000 00000000 0 1234567800002000
LOAD    00005000 00000000 0 ffffafff00007700
IDLE    00000000 00000004 0 0
